/* source/cam_defines.svh */
`ifndef CAM_DEFINES_SVH
`define CAM_DEFINES_SVH

// sensor clock is 74.25 MHz
`define CAM_TICKS_PER_MS    32'd74250

`define CAM_PWUP_MS         100
`define CAM_INIT_MS         150
`define CAM_SRST_WAIT_MS    8'd10

`define CAM_SYS_CLK_ADDR    16'h3103
`define CAM_SYS_CLK_DATA    8'h11
`define CAM_SRST_ADDR       16'h3008
`define CAM_SRST_DATA       8'h82
`define CAM_DELAY_MARK      16'hffff

`define CAM_CSR_SLAVE_ADDR  8'h04
`define CAM_CSR_SLAVE_DATA  32'h0000_0001
`define CAM_CSR_PHY_ADDR    8'h08
`define CAM_CSR_PHY_DATA    32'h0000_003c

`endif

/* source/cam_pwup_pkg.sv */
`include "cam_defines.svh"

package cam_pwup_pkg;

typedef enum logic [3:0] {
  PWR_DOWN,
  SET_SLAVE,
  SYS_CLK,
  SOFT_RST,
  SRST_WAIT,
  CFG_INIT,
  CMD_DELAY,
  SET_MODE,
  RUN_PHY,
  RUN
} seq_state_e;

typedef struct packed {
  logic [15:0] addr;
  logic [7:0]  data;
} cam_wr_t;

typedef struct packed {
  logic [15:0] mark;  // CAM_DELAY_MARK
  logic [7:0]  ms;
} cam_dly_t;

// a table entry is either a register write or a delay request
typedef union packed {
  cam_wr_t  wr;
  cam_dly_t dly;
} cam_cmd_u;

localparam int INIT_OPS = 8;
localparam int MODE_OPS = 5;

localparam cam_cmd_u INIT_TABLE [INIT_OPS] = '{
  24'h3034_18,                 // mipi 8 bit
  24'h3035_11,
  24'h3036_54,                 // pll multiplier
  24'h3037_13,
  {`CAM_DELAY_MARK, 8'd3},     // let the pll settle
  24'h3108_01,
  24'h3630_36,
  24'h3631_0e
};

localparam cam_cmd_u MODE_TABLE [MODE_OPS] = '{
  24'h3808_07,                 // width 1920
  24'h3809_80,
  24'h380a_04,                 // height 1080
  24'h380b_38,
  24'h4300_30                  // yuv422
};

endpackage

/* source/cam_delay_timer.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_delay_timer #(
  parameter int TICKS_PER_MS = `CAM_TICKS_PER_MS
)(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       restart_i,
  input  logic       wait_start_i,
  input  logic [7:0] wait_ms_i,
  output logic       pwup_o,
  output logic       init_ok_o,
  output logic       wait_done_o
);

localparam logic [31:0] PWUP_TICKS = 32'( `CAM_PWUP_MS * TICKS_PER_MS );
localparam logic [31:0] INIT_TICKS = 32'( `CAM_INIT_MS * TICKS_PER_MS );
localparam logic [31:0] MS_LAST    = 32'( TICKS_PER_MS - 1 );

logic [31:0] pwup_cnt;
logic [31:0] pre_cnt;
logic [7:0]  ms_cnt;
logic        busy;

////////////////////////////////////////////////////////////
// power-up counter, saturates at init time

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    pwup_cnt <= '0;
  else if( restart_i )
    pwup_cnt <= '0;
  else if( pwup_cnt != INIT_TICKS )
    pwup_cnt <= pwup_cnt + 1'b1;

assign pwup_o    = pwup_cnt >= PWUP_TICKS;
assign init_ok_o = pwup_cnt == INIT_TICKS;

////////////////////////////////////////////////////////////
// millisecond waits

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      busy        <= 1'b0;
      pre_cnt     <= '0;
      ms_cnt      <= '0;
      wait_done_o <= 1'b0;
    end
  else
    begin
      wait_done_o <= 1'b0;
      if( restart_i )
        busy <= 1'b0;
      else if( wait_start_i )
        begin
          busy    <= 1'b1;
          pre_cnt <= MS_LAST;
          ms_cnt  <= wait_ms_i;
        end
      else if( busy )
        begin
          if( pre_cnt != '0 )
            pre_cnt <= pre_cnt - 1'b1;
          else
            begin
              pre_cnt <= MS_LAST;                // one ms elapsed
              ms_cnt  <= ms_cnt - 1'b1;
              if( ms_cnt == 8'd1 )
                begin
                  busy        <= 1'b0;
                  wait_done_o <= 1'b1;
                end
            end
        end
    end

a_no_start_busy: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  wait_start_i |-> !busy );

endmodule

/* source/cam_cmd_rom.sv */
`timescale 1ns/1ps

module cam_cmd_rom
  import cam_pwup_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     restart_i,
  input  logic     next_i,
  input  logic     mode_sel_i,
  output cam_cmd_u cmd_o,
  output logic     last_o
);

localparam int INIT_W = $clog2( INIT_OPS );
localparam int MODE_W = $clog2( MODE_OPS );

logic [INIT_W-1:0] init_idx;
logic [MODE_W-1:0] mode_idx;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      init_idx <= '0;
      mode_idx <= '0;
    end
  else if( restart_i )
    begin
      init_idx <= '0;
      mode_idx <= '0;
    end
  else if( next_i )
    begin
      if( mode_sel_i )
        mode_idx <= mode_idx + 1'b1;
      else
        init_idx <= init_idx + 1'b1;
    end

assign cmd_o  = mode_sel_i ? MODE_TABLE[mode_idx] : INIT_TABLE[init_idx];
assign last_o = mode_sel_i ? ( mode_idx == MODE_W'( MODE_OPS - 1 ) ) :
                             ( init_idx == INIT_W'( INIT_OPS - 1 ) );

// sequencer must leave the table on the last entry
a_no_next_last: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  next_i |-> !last_o );

endmodule

/* source/cam_reg_write_port.sv */
`timescale 1ns/1ps

module cam_reg_write_port #(
  parameter int ADDR_W = 16,
  parameter int DATA_W = 8
)(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic              ack_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic [DATA_W-1:0] data_o,
  output logic              wr_o,
  output logic              done_o
);

// held steady for the whole request
always_ff @( posedge clk_i )
  if( start_i )
    begin
      addr_o <= addr_i;
      data_o <= data_i;
    end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      wr_o   <= 1'b0;
      done_o <= 1'b0;
    end
  else
    begin
      done_o <= wr_o && ack_i;             // one cycle after ack
      if( start_i )
        wr_o <= 1'b1;
      else if( ack_i )
        wr_o <= 1'b0;
    end

// the sequencer waits for done before the next write
a_no_start_busy: assert property ( @( posedge clk_i ) disable iff ( rst_i )
  start_i |-> !wr_o );

endmodule

/* source/cam_seq_fsm.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_seq_fsm
  import cam_pwup_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cam_rst_stb_i,
  input  logic        init_ok_i,
  input  logic        wait_done_i,
  input  cam_cmd_u    cmd_i,
  input  logic        last_i,
  input  logic        sccb_done_i,
  input  logic        csr_done_i,
  output logic        restart_o,
  output logic        wait_start_o,
  output logic [7:0]  wait_ms_o,
  output logic        next_o,
  output logic        mode_sel_o,
  output logic        sccb_start_o,
  output logic [15:0] sccb_addr_o,
  output logic [7:0]  sccb_data_o,
  output logic        csr_start_o,
  output logic [7:0]  csr_addr_o,
  output logic [31:0] csr_data_o,
  output logic        init_done_o
);

seq_state_e state;
seq_state_e next_state;
logic       issued;     // request of this step is out
logic       is_delay;

assign is_delay = cmd_i.dly.mark == `CAM_DELAY_MARK;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    state <= PWR_DOWN;
  else
    state <= next_state;

always_comb
  begin
    next_state = state;
    case( state )
      PWR_DOWN:
        if( init_ok_i )
          next_state = SET_SLAVE;
      SET_SLAVE:
        if( csr_done_i )
          next_state = SYS_CLK;
      SYS_CLK:
        if( sccb_done_i )
          next_state = SOFT_RST;
      SOFT_RST:
        if( sccb_done_i )
          next_state = SRST_WAIT;
      SRST_WAIT:
        if( wait_done_i )
          next_state = CFG_INIT;
      CFG_INIT:
        if( !issued && is_delay )
          next_state = CMD_DELAY;            // no write for a marker
        else if( sccb_done_i && last_i )
          next_state = SET_MODE;
      CMD_DELAY:
        if( wait_done_i )
          next_state = last_i ? SET_MODE : CFG_INIT;
      SET_MODE:
        if( sccb_done_i && last_i )
          next_state = RUN_PHY;
      RUN_PHY:
        if( csr_done_i )
          next_state = RUN;
      RUN:
        if( cam_rst_stb_i )
          next_state = PWR_DOWN;
      default:
        next_state = PWR_DOWN;
    endcase
  end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    issued <= 1'b0;
  else if( sccb_done_i || csr_done_i || wait_done_i )
    issued <= 1'b0;
  else if( sccb_start_o || csr_start_o || wait_start_o )
    issued <= 1'b1;

////////////////////////////////////////////////////////////
// requests

assign sccb_start_o = !issued && ( state == SYS_CLK || state == SOFT_RST ||
                                   state == SET_MODE || ( state == CFG_INIT && !is_delay ) );
assign csr_start_o  = !issued && ( state == SET_SLAVE || state == RUN_PHY );
assign wait_start_o = !issued && ( state == SRST_WAIT || state == CMD_DELAY );
assign wait_ms_o    = ( state == CMD_DELAY ) ? cmd_i.dly.ms : `CAM_SRST_WAIT_MS;

assign next_o = !last_i && ( ( sccb_done_i && ( state == CFG_INIT || state == SET_MODE ) ) ||
                             ( wait_done_i && state == CMD_DELAY ) );

always_comb
  case( state )
    SYS_CLK:
      begin
        sccb_addr_o = `CAM_SYS_CLK_ADDR;
        sccb_data_o = `CAM_SYS_CLK_DATA;
      end
    SOFT_RST:
      begin
        sccb_addr_o = `CAM_SRST_ADDR;
        sccb_data_o = `CAM_SRST_DATA;
      end
    default:
      begin
        sccb_addr_o = cmd_i.wr.addr;         // init or mode table
        sccb_data_o = cmd_i.wr.data;
      end
  endcase

assign csr_addr_o  = ( state == RUN_PHY ) ? `CAM_CSR_PHY_ADDR : `CAM_CSR_SLAVE_ADDR;
assign csr_data_o  = ( state == RUN_PHY ) ? `CAM_CSR_PHY_DATA : `CAM_CSR_SLAVE_DATA;

assign mode_sel_o  = state == SET_MODE;
assign restart_o   = state == RUN && cam_rst_stb_i;   // strobe ignored elsewhere
assign init_done_o = state == RUN;

endmodule

/* source/cam_pwup_top.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_pwup_top
  import cam_pwup_pkg::*;
#(
  parameter int TICKS_PER_MS = `CAM_TICKS_PER_MS
)(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cam_rst_stb_i,
  output logic        cam_pwup_o,
  output logic        init_done_o,
  output logic [15:0] sccb_addr_o,
  output logic [7:0]  sccb_data_o,
  output logic        sccb_wr_o,
  input  logic        sccb_ack_i,
  output logic [7:0]  csr_addr_o,
  output logic [31:0] csr_data_o,
  output logic        csr_wr_o,
  input  logic        csr_ack_i
);

logic        restart;
logic        init_ok;
logic        wait_start;
logic [7:0]  wait_ms;
logic        wait_done;
logic        cmd_next;
logic        mode_sel;
logic        cmd_last;
cam_cmd_u    cmd;
logic        sccb_start;
logic [15:0] sccb_addr;
logic [7:0]  sccb_data;
logic        sccb_done;
logic        csr_start;
logic [7:0]  csr_addr;
logic [31:0] csr_data;
logic        csr_done;

cam_seq_fsm seq_fsm (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .cam_rst_stb_i ( cam_rst_stb_i ),
  .init_ok_i     ( init_ok       ),
  .wait_done_i   ( wait_done     ),
  .cmd_i         ( cmd           ),
  .last_i        ( cmd_last      ),
  .sccb_done_i   ( sccb_done     ),
  .csr_done_i    ( csr_done      ),
  .restart_o     ( restart       ),
  .wait_start_o  ( wait_start    ),
  .wait_ms_o     ( wait_ms       ),
  .next_o        ( cmd_next      ),
  .mode_sel_o    ( mode_sel      ),
  .sccb_start_o  ( sccb_start    ),
  .sccb_addr_o   ( sccb_addr     ),
  .sccb_data_o   ( sccb_data     ),
  .csr_start_o   ( csr_start     ),
  .csr_addr_o    ( csr_addr      ),
  .csr_data_o    ( csr_data      ),
  .init_done_o   ( init_done_o   )
);

cam_delay_timer #(
  .TICKS_PER_MS  ( TICKS_PER_MS  )
) delay_timer (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .restart_i     ( restart       ),
  .wait_start_i  ( wait_start    ),
  .wait_ms_i     ( wait_ms       ),
  .pwup_o        ( cam_pwup_o    ),
  .init_ok_o     ( init_ok       ),
  .wait_done_o   ( wait_done     )
);

cam_cmd_rom cmd_rom (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .restart_i     ( restart       ),
  .next_i        ( cmd_next      ),
  .mode_sel_i    ( mode_sel      ),
  .cmd_o         ( cmd           ),
  .last_o        ( cmd_last      )
);

// sensor register port
cam_reg_write_port #(
  .ADDR_W        ( 16            ),
  .DATA_W        ( 8             )
) sccb_port (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .start_i       ( sccb_start    ),
  .addr_i        ( sccb_addr     ),
  .data_i        ( sccb_data     ),
  .ack_i         ( sccb_ack_i    ),
  .addr_o        ( sccb_addr_o   ),
  .data_o        ( sccb_data_o   ),
  .wr_o          ( sccb_wr_o     ),
  .done_o        ( sccb_done     )
);

// receiver csr port
cam_reg_write_port #(
  .ADDR_W        ( 8             ),
  .DATA_W        ( 32            )
) csr_port (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .start_i       ( csr_start     ),
  .addr_i        ( csr_addr      ),
  .data_i        ( csr_data      ),
  .ack_i         ( csr_ack_i     ),
  .addr_o        ( csr_addr_o    ),
  .data_o        ( csr_data_o    ),
  .wr_o          ( csr_wr_o      ),
  .done_o        ( csr_done      )
);

endmodule

/* tb/cam_pwup_checker.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_pwup_checker
  import cam_pwup_pkg::*;
#(
  parameter int TICKS_PER_MS = 10
)(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cam_rst_stb_i,
  input  logic        cam_pwup_i,
  input  logic        init_done_i,
  input  logic [15:0] sccb_addr_i,
  input  logic [7:0]  sccb_data_i,
  input  logic        sccb_wr_i,
  input  logic        sccb_ack_i,
  input  logic [7:0]  csr_addr_i,
  input  logic [31:0] csr_data_i,
  input  logic        csr_wr_i,
  input  logic        csr_ack_i,
  input  logic        count_check_i,
  input  logic [3:0]  exp_seqs_i,
  output int          errors_o
);

localparam int PWUP_TICKS = `CAM_PWUP_MS * TICKS_PER_MS;
localparam int INIT_TICKS = `CAM_INIT_MS * TICKS_PER_MS;
localparam int MAX_WR     = INIT_OPS + MODE_OPS + 4;
localparam int DONE_LAT   = 4;      // final ack to init_done_o

logic        exp_csr  [MAX_WR];
logic [31:0] exp_addr [MAX_WR];
logic [31:0] exp_data [MAX_WR];
int          exp_gap  [MAX_WR];     // min cycles after previous ack
int          n_exp;

int          cyc;
int          idx;
int          last_ack;
int          done_wait;
int          done_cnt;
int          errors;
logic        exp_pwup;
logic        prev_sccb_wr;
logic        prev_csr_wr;
logic        prev_done;
logic [31:0] prev_sccb_addr;
logic [31:0] prev_sccb_data;
logic [31:0] prev_csr_addr;
logic [31:0] prev_csr_data;

assign errors_o = errors;

task automatic report_value( input string name, input logic [31:0] got,
                             input logic [31:0] exp );
  $display( "ERR %0t %s: got %0h, expected %0h", $time, name, got, exp );
  errors++;
endtask

task automatic push_write( input logic csr, input logic [31:0] addr,
                           input logic [31:0] data, input int gap );
  exp_csr[n_exp]  = csr;
  exp_addr[n_exp] = addr;
  exp_data[n_exp] = data;
  exp_gap[n_exp]  = gap;
  n_exp++;
endtask

////////////////////////////////////////////////////////////
// expected write list

initial
  begin
    int gap;
    errors = 0;
    n_exp  = 0;
    push_write( 1'b1, 32'( `CAM_CSR_SLAVE_ADDR ), `CAM_CSR_SLAVE_DATA, 0 );
    push_write( 1'b0, 32'( `CAM_SYS_CLK_ADDR ), 32'( `CAM_SYS_CLK_DATA ), 0 );
    push_write( 1'b0, 32'( `CAM_SRST_ADDR ), 32'( `CAM_SRST_DATA ), 0 );
    gap = int'( `CAM_SRST_WAIT_MS ) * TICKS_PER_MS;
    for( int i = 0; i < INIT_OPS; i++ )
      if( INIT_TABLE[i].dly.mark == `CAM_DELAY_MARK )
        gap = gap + int'( INIT_TABLE[i].dly.ms ) * TICKS_PER_MS;   // no write for a marker
      else
        begin
          push_write( 1'b0, 32'( INIT_TABLE[i].wr.addr ), 32'( INIT_TABLE[i].wr.data ), gap );
          gap = 0;
        end
    for( int i = 0; i < MODE_OPS; i++ )
      begin
        push_write( 1'b0, 32'( MODE_TABLE[i].wr.addr ), 32'( MODE_TABLE[i].wr.data ), gap );
        gap = 0;
      end
    push_write( 1'b1, 32'( `CAM_CSR_PHY_ADDR ), `CAM_CSR_PHY_DATA, gap );
  end

task automatic watch_port( input logic csr, input logic wr, input logic ack,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic prev_wr, input logic [31:0] prev_addr,
                           input logic [31:0] prev_data );
  string pfx;
  pfx = csr ? "csr" : "sccb";
  if( wr && cyc < INIT_TICKS )
    report_value( { pfx, "_wr_o" }, 32'd1, 32'd0 );      // still in power-down
  if( wr && prev_wr )
    begin
      if( addr != prev_addr )
        report_value( { pfx, "_addr_o" }, addr, prev_addr );
      if( data != prev_data )
        report_value( { pfx, "_data_o" }, data, prev_data );
    end
  if( wr && !prev_wr )
    begin
      if( idx >= n_exp )
        report_value( { pfx, "_wr_o" }, 32'd1, 32'd0 );
      else if( cyc - last_ack < exp_gap[idx] )
        begin
          $display( "ERR %0t %s_wr_o: request %0d cycles after last ack, expected at least %0d",
                    $time, pfx, cyc - last_ack, exp_gap[idx] );
          errors++;
        end
    end
  if( wr && ack && idx < n_exp )
    begin
      if( exp_csr[idx] != csr )
        report_value( { pfx, "_wr_o" }, 32'd1, 32'd0 );  // wrong port
      else
        begin
          if( addr != exp_addr[idx] )
            report_value( { pfx, "_addr_o" }, addr, exp_addr[idx] );
          if( data != exp_data[idx] )
            report_value( { pfx, "_data_o" }, data, exp_data[idx] );
        end
      idx++;
      last_ack = cyc;
      if( idx == n_exp )
        done_wait = 0;
    end
endtask

////////////////////////////////////////////////////////////
// per-cycle checks

always @( posedge clk_i )
  if( rst_i )
    begin
      cyc          = 0;
      idx          = 0;
      last_ack     = 0;
      done_wait    = -1;
      done_cnt     = 0;
      prev_sccb_wr = 1'b0;
      prev_csr_wr  = 1'b0;
      prev_done    = 1'b0;
    end
  else
    begin
      exp_pwup = cyc >= PWUP_TICKS;
      if( cam_pwup_i !== exp_pwup )
        report_value( "cam_pwup_o", 32'( cam_pwup_i ), 32'( exp_pwup ) );
      watch_port( 1'b1, csr_wr_i, csr_ack_i, 32'( csr_addr_i ), csr_data_i,
                  prev_csr_wr, prev_csr_addr, prev_csr_data );
      watch_port( 1'b0, sccb_wr_i, sccb_ack_i, 32'( sccb_addr_i ), 32'( sccb_data_i ),
                  prev_sccb_wr, prev_sccb_addr, prev_sccb_data );
      if( init_done_i )
        begin
          if( idx < n_exp )
            report_value( "init_done_o", 32'd1, 32'd0 );
          done_wait = -1;
        end
      else if( done_wait >= 0 )
        begin
          done_wait++;
          if( done_wait > DONE_LAT )
            begin
              report_value( "init_done_o", 32'd0, 32'd1 );
              done_wait = -1;
            end
        end
      if( init_done_i && !prev_done )
        done_cnt++;                                       // one full sequence
      if( count_check_i && done_cnt != int'( exp_seqs_i ) )
        report_value( "init_done_o count", 32'( done_cnt ), 32'( exp_seqs_i ) );
      if( cam_rst_stb_i && idx == n_exp && done_wait < 0 )
        begin
          cyc      = 0;                                   // restart from run
          idx      = 0;
          last_ack = 0;
        end
      else
        cyc++;
      prev_sccb_wr   = sccb_wr_i;
      prev_sccb_addr = 32'( sccb_addr_i );
      prev_sccb_data = 32'( sccb_data_i );
      prev_csr_wr    = csr_wr_i;
      prev_csr_addr  = 32'( csr_addr_i );
      prev_csr_data  = csr_data_i;
      prev_done      = init_done_i;
    end

endmodule

/* tb/cam_pwup_tb.sv */
`timescale 1ns/1ps
`include "cam_defines.svh"

module cam_pwup_tb;

localparam int TICKS      = 10;
localparam int DONE_LIMIT = ( `CAM_INIT_MS + 100 ) * TICKS;
localparam int REQ_LIMIT  = ( `CAM_INIT_MS + 20 ) * TICKS;
localparam int FALL_LIMIT = 8;

localparam logic [1:0] ACK_ZERO  = 2'd0;
localparam logic [1:0] ACK_FIXED = 2'd1;
localparam logic [1:0] ACK_RAND  = 2'd2;

typedef struct packed {
  logic [1:0] ack_mode;
  logic       early_stb;    // strobes in power-down and during a write
  logic [3:0] exp_seqs;
} scen_t;

localparam int N_SCEN = 4;
localparam scen_t SCEN_TABLE [N_SCEN] = '{
  '{ ACK_ZERO,  1'b0, 4'd1 },
  '{ ACK_FIXED, 1'b1, 4'd2 },
  '{ ACK_RAND,  1'b1, 4'd2 },
  '{ ACK_RAND,  1'b0, 4'd3 }
};

logic        clk;
logic        rst;
logic        cam_rst_stb;
logic        cam_pwup;
logic        init_done;
logic [15:0] sccb_addr;
logic [7:0]  sccb_data;
logic        sccb_wr;
logic        sccb_ack = 1'b0;
logic [7:0]  csr_addr;
logic [31:0] csr_data;
logic        csr_wr;
logic        csr_ack = 1'b0;
logic [1:0]  ack_mode;
int          sccb_cnt = 0;
int          csr_cnt = 0;
logic        count_check;
logic [3:0]  exp_seqs;
int          value_errs;
int          fails;
bit          aborted;

cam_pwup_top #(
  .TICKS_PER_MS  ( TICKS       )
) DUT (
  .clk_i         ( clk         ),
  .rst_i         ( rst         ),
  .cam_rst_stb_i ( cam_rst_stb ),
  .cam_pwup_o    ( cam_pwup    ),
  .init_done_o   ( init_done   ),
  .sccb_addr_o   ( sccb_addr   ),
  .sccb_data_o   ( sccb_data   ),
  .sccb_wr_o     ( sccb_wr     ),
  .sccb_ack_i    ( sccb_ack    ),
  .csr_addr_o    ( csr_addr    ),
  .csr_data_o    ( csr_data    ),
  .csr_wr_o      ( csr_wr      ),
  .csr_ack_i     ( csr_ack     )
);

cam_pwup_checker #(
  .TICKS_PER_MS  ( TICKS       )
) chk (
  .clk_i         ( clk         ),
  .rst_i         ( rst         ),
  .cam_rst_stb_i ( cam_rst_stb ),
  .cam_pwup_i    ( cam_pwup    ),
  .init_done_i   ( init_done   ),
  .sccb_addr_i   ( sccb_addr   ),
  .sccb_data_i   ( sccb_data   ),
  .sccb_wr_i     ( sccb_wr     ),
  .sccb_ack_i    ( sccb_ack    ),
  .csr_addr_i    ( csr_addr    ),
  .csr_data_i    ( csr_data    ),
  .csr_wr_i      ( csr_wr      ),
  .csr_ack_i     ( csr_ack     ),
  .count_check_i ( count_check ),
  .exp_seqs_i    ( exp_seqs    ),
  .errors_o      ( value_errs  )
);

initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

function automatic int draw_delay();
  case( ack_mode )
    ACK_ZERO:  return 0;
    ACK_FIXED: return 3;
    default:   return int'( $urandom % 32'd6 );
  endcase
endfunction

////////////////////////////////////////////////////////////
// slave models, ack after the drawn delay

always @( posedge clk )
  if( sccb_ack )
    sccb_ack <= 1'b0;
  else if( sccb_wr )
    begin
      if( sccb_cnt == 0 )
        sccb_ack <= 1'b1;
      else
        sccb_cnt <= sccb_cnt - 1;
    end
  else
    sccb_cnt <= draw_delay();

always @( posedge clk )
  if( csr_ack )
    csr_ack <= 1'b0;
  else if( csr_wr )
    begin
      if( csr_cnt == 0 )
        csr_ack <= 1'b1;
      else
        csr_cnt <= csr_cnt - 1;
    end
  else
    csr_cnt <= draw_delay();

task automatic pulse_strobe();
  cam_rst_stb <= 1'b1;
  @( posedge clk );
  cam_rst_stb <= 1'b0;
endtask

task automatic wait_done_level( input logic level, input int limit );
  int  n;
  bit  seen;
  n    = 0;
  seen = 1'b0;
  while( !seen && n < limit )
    begin
      @( posedge clk );
      seen = init_done === level;
      n++;
    end
  if( !seen )
    begin
      $display( "timeout: init_done_o did not go to %0d within %0d cycles", level, limit );
      fails++;
      aborted = 1'b1;
    end
endtask

task automatic wait_sensor_request( input int limit );
  int  n;
  bit  seen;
  n    = 0;
  seen = 1'b0;
  while( !seen && n < limit )
    begin
      @( posedge clk );
      seen = sccb_wr === 1'b1;
      n++;
    end
  if( !seen )
    begin
      $display( "timeout: no sensor write request within %0d cycles", limit );
      fails++;
      aborted = 1'b1;
    end
endtask

task automatic run_scenario( input scen_t sc );
  @( posedge clk );
  ack_mode <= sc.ack_mode;
  rst      <= 1'b1;
  repeat( 2 ) @( posedge clk );
  rst <= 1'b0;
  for( int s = 0; s < int'( sc.exp_seqs ) && !aborted; s++ )
    begin
      if( sc.early_stb )
        begin
          repeat( `CAM_PWUP_MS / 2 * TICKS ) @( posedge clk );
          pulse_strobe();                               // deep in power-down
          wait_sensor_request( REQ_LIMIT );
          if( !aborted )
            pulse_strobe();                             // sensor write pending
        end
      if( !aborted )
        wait_done_level( 1'b1, DONE_LIMIT );
      if( !aborted && s < int'( sc.exp_seqs ) - 1 )
        begin
          pulse_strobe();                               // restart from run
          wait_done_level( 1'b0, FALL_LIMIT );
        end
    end
  if( !aborted )
    begin
      exp_seqs    <= sc.exp_seqs;
      count_check <= 1'b1;
      @( posedge clk );
      count_check <= 1'b0;
    end
endtask

initial
  begin
    void'( $urandom( 67196 ) );
    rst         = 1'b1;
    cam_rst_stb = 1'b0;
    ack_mode    = ACK_ZERO;
    count_check = 1'b0;
    exp_seqs    = 4'd0;
    fails       = 0;
    aborted     = 1'b0;
    for( int i = 0; i < N_SCEN && !aborted; i++ )
      run_scenario( SCEN_TABLE[i] );
    repeat( 4 ) @( posedge clk );
    $display( "checker errors: %0d, other failures: %0d", value_errs, fails );
    if( value_errs == 0 && fails == 0 )
      $display( "Test completed successfully" );
    else
      $display( "Test failed" );
    $finish;
  end

endmodule

/* list.f */
+incdir+source
source/cam_pwup_pkg.sv
source/cam_delay_timer.sv
source/cam_cmd_rom.sv
source/cam_reg_write_port.sv
source/cam_seq_fsm.sv
source/cam_pwup_top.sv
tb/cam_pwup_checker.sv
tb/cam_pwup_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cam_pwup_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
